// ==== bank_arbiter.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "vrf_defines.svh"

module bank_arbiter (
  input  wire logic                                 clk_i,
  input  wire logic                                 rst_ni,
  // Masters
  input  wire logic [`NR_MASTERS-1:0]               req_i,
  input  wire vrf_pkg::vrf_req_t [`NR_MASTERS-1:0]  payload_i,
  output logic [`NR_MASTERS-1:0]                    gnt_o,
  // Register-file bank
  output vrf_pkg::vrf_req_t                         vrf_o,
  output logic                                      vrf_valid_o
);

  localparam int unsigned NR_M  = `NR_MASTERS;
  localparam int unsigned IDX_W = $clog2(NR_M);

  logic [NR_M-1:0]  req_hp, req_lp;
  logic [NR_M-1:0]  gnt_hp, gnt_lp;
  logic [IDX_W-1:0] ptr_hp_d, ptr_hp_q;
  logic [IDX_W-1:0] ptr_lp_d, ptr_lp_q;

  // First requester at or after ptr, wrapping around
  function automatic logic [NR_M-1:0] rr_pick(input logic [NR_M-1:0]  req,
                                              input logic [IDX_W-1:0] ptr);
    logic [NR_M-1:0] gnt;
    logic            found;
    int unsigned     idx;
    gnt   = '0;
    found = 1'b0;
    for (int unsigned i = 0; i < NR_M; i++) begin
      idx = (32'(ptr) + i) % NR_M;
      if (req[idx] && !found) begin
        gnt[idx] = 1'b1;
        found    = 1'b1;
      end
    end
    return gnt;
  endfunction

  //////////////////////////////////////////////////
  // Two-class selection
  //////////////////////////////////////////////////

  assign req_hp = req_i & vrf_pkg::HP_MASK;
  assign req_lp = req_i & ~vrf_pkg::HP_MASK;

  assign gnt_hp = rr_pick(req_hp, ptr_hp_q);
  assign gnt_lp = rr_pick(req_lp, ptr_lp_q);

  // Any high-priority request masks the low class
  assign gnt_o       = (|req_hp) ? gnt_hp : gnt_lp;
  assign vrf_valid_o = |req_i;

  always_comb begin
    vrf_o = '0;
    for (int m = 0; m < NR_M; m++) begin
      if (gnt_o[m]) begin
        vrf_o = payload_i[m];
      end
    end
  end

  //////////////////////////////////////////////////
  // Round-robin pointers
  //////////////////////////////////////////////////

  always_comb begin
    ptr_hp_d = ptr_hp_q;
    ptr_lp_d = ptr_lp_q;
    for (int m = 0; m < NR_M; m++) begin
      if (gnt_o[m] && vrf_pkg::HP_MASK[m]) begin
        ptr_hp_d = IDX_W'((m + 1) % NR_M);
      end
      if (gnt_o[m] && !vrf_pkg::HP_MASK[m]) begin
        ptr_lp_d = IDX_W'((m + 1) % NR_M);
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ptr_hp_q <= '0;
      ptr_lp_q <= '0;
    end else begin
      ptr_hp_q <= ptr_hp_d;
      ptr_lp_q <= ptr_lp_d;
    end
  end

  a_gnt_legal: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $onehot0(gnt_o) && ((gnt_o & ~req_i) == '0))
    else $error("bank grant is not one-hot or has no matching request");

endmodule

`default_nettype wire

// ==== operand_fetcher.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "vrf_defines.svh"

module operand_fetcher #(
  parameter vrf_pkg::opqueue_e QUEUE = vrf_pkg::ALU_A
) (
  input  wire logic                      clk_i,
  input  wire logic                      rst_ni,
  // Read command
  input  wire vrf_pkg::operand_request_t req_i,
  input  wire logic                      req_valid_i,
  output logic                           req_ready_o,
  // Operand queue
  input  wire logic                      opq_ready_i,
  output vrf_pkg::opqueue_cmd_t          opq_cmd_o,
  output logic                           opq_cmd_valid_o,
  output logic                           issued_o,
  // Bank arbiters
  output logic [`NR_BANKS-1:0]           bank_req_o,
  output vrf_pkg::vrf_req_t              bank_req_o_payload,
  input  wire logic [`NR_BANKS-1:0]      bank_gnt_i
);

  localparam int unsigned BANK_W = `BANK_W;
  localparam int unsigned LEN_W  = `VL_W;

  typedef enum logic {
    IDLE,
    REQUESTING
  } state_e;

  // Progress through the current vector operand
  typedef struct packed {
    vrf_pkg::vaddr_t  addr;
    logic [LEN_W-1:0] len;
    vrf_pkg::vew_e    eew;
  } meta_t;

  state_e           state_d, state_q;
  meta_t            meta_d, meta_q;
  logic             req_active;
  logic             granted;
  logic             can_accept;
  logic             accept;
  logic [LEN_W-1:0] step;

  assign req_active = (state_q == REQUESTING) && opq_ready_i;
  assign granted    = |bank_gnt_i;
  assign issued_o   = granted;

  // Elements per 64-bit word
  assign step = LEN_W'(8) >> meta_q.eew;

  //////////////////////////////////////////////////
  // Bank request
  //////////////////////////////////////////////////

  always_comb begin
    for (int b = 0; b < `NR_BANKS; b++) begin
      bank_req_o[b] = req_active && (meta_q.addr[BANK_W-1:0] == BANK_W'(b));
    end
  end

  // Reads carry no data, only the row and the destination queue
  assign bank_req_o_payload = '{
    row:     meta_q.addr[`VADDR_W-1:BANK_W],
    wen:     1'b0,
    wdata:   '0,
    be:      '0,
    opqueue: QUEUE
  };

  //////////////////////////////////////////////////
  // Command handling
  //////////////////////////////////////////////////

  always_comb begin
    state_d    = state_q;
    meta_d     = meta_q;
    can_accept = 1'b0;

    if (state_q == IDLE) begin
      can_accept = 1'b1;
    end else if (req_active) begin
      if (granted) begin
        meta_d.addr = meta_q.addr + 1'b1;
        meta_d.len  = (meta_q.len <= step) ? '0 : meta_q.len - step;
      end
      // Last word granted, a new command may follow right away
      if (meta_d.len == '0) begin
        state_d    = IDLE;
        can_accept = 1'b1;
      end
    end

    accept = req_valid_i && can_accept;
    if (accept) begin
      meta_d.addr = vrf_pkg::vaddr_t'(req_i.vs * vrf_pkg::VRF_BASE_STRIDE);
      meta_d.len  = req_i.vl;
      meta_d.eew  = req_i.eew;
      // A zero length is acknowledged and dropped
      state_d     = (req_i.vl != '0) ? REQUESTING : IDLE;
    end
  end

  assign req_ready_o     = accept;
  assign opq_cmd_valid_o = accept && (req_i.vl != '0);
  assign opq_cmd_o       = '{eew: req_i.eew, elem_count: req_i.vl};

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= IDLE;
      meta_q  <= '0;
    end else begin
      state_q <= state_d;
      meta_q  <= meta_d;
    end
  end

  a_one_bank: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $onehot0(bank_req_o))
    else $error("fetcher requests more than one bank");

  a_len_falls: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (state_q == REQUESTING && !accept) |=> (meta_q.len <= $past(meta_q.len)))
    else $error("remaining element count rose without a new command");

endmodule

`default_nettype wire

// ==== operand_requester.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "vrf_defines.svh"

module operand_requester (
  input  wire logic                                      clk_i,
  input  wire logic                                      rst_ni,
  // Read commands, one per operand queue
  input  wire vrf_pkg::operand_request_t [`NR_OPQ-1:0]   op_req_i,
  input  wire logic [`NR_OPQ-1:0]                        op_req_valid_i,
  output logic [`NR_OPQ-1:0]                             op_req_ready_o,
  // Operand queues
  input  wire logic [`NR_OPQ-1:0]                        opq_ready_i,
  output vrf_pkg::opqueue_cmd_t [`NR_OPQ-1:0]            opq_cmd_o,
  output logic [`NR_OPQ-1:0]                             opq_cmd_valid_o,
  output logic [`NR_OPQ-1:0]                             operand_issued_o,
  // ALU write-back
  input  wire vrf_pkg::wb_result_t                       alu_res_i,
  input  wire logic                                      alu_req_i,
  output logic                                           alu_gnt_o,
  // Load-unit write-back
  input  wire vrf_pkg::wb_result_t                       ldu_res_i,
  input  wire logic                                      ldu_req_i,
  output logic                                           ldu_gnt_o,
  output logic                                           ldu_final_gnt_o,
  // Register-file banks
  output vrf_pkg::vrf_req_t [`NR_BANKS-1:0]              vrf_o,
  output logic [`NR_BANKS-1:0]                           vrf_valid_o
);

  localparam int unsigned BANK_W = `BANK_W;
  localparam int unsigned ALU_WB = `NR_OPQ;
  localparam int unsigned LDU_WB = `NR_OPQ + 1;

  logic [`NR_BANKS-1:0][`NR_MASTERS-1:0] bank_req, bank_gnt;
  vrf_pkg::vrf_req_t [`NR_MASTERS-1:0]   payload;
  logic [`NR_OPQ-1:0][`NR_BANKS-1:0]     fetch_req, fetch_gnt;
  logic [`NR_BANKS-1:0]                  alu_bank_gnt, ldu_bank_gnt;

  vrf_pkg::wb_result_t ldu_res;
  logic                ldu_req;
  logic                ldu_gnt;

  function automatic vrf_pkg::vrf_req_t wb_payload(input vrf_pkg::wb_result_t res);
    // Queue tag has no meaning on a write
    return '{
      row:     res.addr[`VADDR_W-1:BANK_W],
      wen:     1'b1,
      wdata:   res.wdata,
      be:      res.be,
      opqueue: vrf_pkg::ALU_A
    };
  endfunction

  //////////////////////////////////////////////////
  // Write-back side
  //////////////////////////////////////////////////

  result_skid result_skid_inst (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .res_i      (ldu_res_i),
    .req_i      (ldu_req_i),
    .gnt_o      (ldu_gnt_o),
    .res_o      (ldu_res),
    .req_o      (ldu_req),
    .gnt_i      (ldu_gnt),
    .final_gnt_o(ldu_final_gnt_o)
  );

  assign payload[ALU_WB] = wb_payload(alu_res_i);
  assign payload[LDU_WB] = wb_payload(ldu_res);

  assign alu_gnt_o = |alu_bank_gnt;
  assign ldu_gnt   = |ldu_bank_gnt;

  //////////////////////////////////////////////////
  // Operand fetchers
  //////////////////////////////////////////////////

  for (genvar q = 0; q < `NR_OPQ; q++) begin : gen_fetcher
    operand_fetcher #(
      .QUEUE(vrf_pkg::opqueue_e'(q))
    ) operand_fetcher_inst (
      .clk_i             (clk_i),
      .rst_ni            (rst_ni),
      .req_i             (op_req_i[q]),
      .req_valid_i       (op_req_valid_i[q]),
      .req_ready_o       (op_req_ready_o[q]),
      .opq_ready_i       (opq_ready_i[q]),
      .opq_cmd_o         (opq_cmd_o[q]),
      .opq_cmd_valid_o   (opq_cmd_valid_o[q]),
      .issued_o          (operand_issued_o[q]),
      .bank_req_o        (fetch_req[q]),
      .bank_req_o_payload(payload[q]),
      .bank_gnt_i        (fetch_gnt[q])
    );
  end

  //////////////////////////////////////////////////
  // Per-bank arbitration
  //////////////////////////////////////////////////

  for (genvar b = 0; b < `NR_BANKS; b++) begin : gen_bank
    for (genvar q = 0; q < `NR_OPQ; q++) begin : gen_opq_route
      assign bank_req[b][q]  = fetch_req[q][b];
      assign fetch_gnt[q][b] = bank_gnt[b][q];
    end

    // Write-backs go to the bank named by the address low bits
    assign bank_req[b][ALU_WB] = alu_req_i && (alu_res_i.addr[BANK_W-1:0] == BANK_W'(b));
    assign bank_req[b][LDU_WB] = ldu_req && (ldu_res.addr[BANK_W-1:0] == BANK_W'(b));
    assign alu_bank_gnt[b]     = bank_gnt[b][ALU_WB];
    assign ldu_bank_gnt[b]     = bank_gnt[b][LDU_WB];

    bank_arbiter bank_arbiter_inst (
      .clk_i      (clk_i),
      .rst_ni     (rst_ni),
      .req_i      (bank_req[b]),
      .payload_i  (payload),
      .gnt_o      (bank_gnt[b]),
      .vrf_o      (vrf_o[b]),
      .vrf_valid_o(vrf_valid_o[b])
    );
  end

endmodule

`default_nettype wire

// ==== result_skid.sv ====
`timescale 1ns/1ps
`default_nettype none

module result_skid (
  input  wire logic                clk_i,
  input  wire logic                rst_ni,
  // From the load unit
  input  wire vrf_pkg::wb_result_t res_i,
  input  wire logic                req_i,
  output logic                     gnt_o,
  // Towards the bank arbiters
  output vrf_pkg::wb_result_t      res_o,
  output logic                     req_o,
  input  wire logic                gnt_i,
  // Write has really reached the bank
  output logic                     final_gnt_o
);

  logic                full_q;
  vrf_pkg::wb_result_t data_q;

  // Free slot, or the held result leaves in this cycle
  assign gnt_o = !full_q || gnt_i;
  assign req_o = full_q;
  assign res_o = data_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      full_q      <= 1'b0;
      final_gnt_o <= 1'b0;
    end else begin
      final_gnt_o <= gnt_i;
      if (req_i && gnt_o) begin
        full_q <= 1'b1;
      end else if (gnt_i) begin
        full_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_i && gnt_o) begin
      data_q <= res_i;
    end
  end

  a_hold_until_gnt: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (req_o && !gnt_i) |=> (req_o && $stable(res_o)))
    else $error("load result changed while waiting for its bank");

endmodule

`default_nettype wire

// ==== run.sh ====
#!/usr/bin/env bash
# Build the testbench with Verilator, run it and look for the pass message
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f src.f --top-module tb_operand_requester \
    -o tb_operand_requester_sim \
  && ./obj_dir/tb_operand_requester_sim | tee /dev/stderr | grep -qF "All tests passed!" \
  && echo "Simulation PASSED" \
  || { echo "Simulation FAILED"; exit 1; }

// ==== src.f ====
+incdir+.
vrf_pkg.sv
result_skid.sv
operand_fetcher.sv
bank_arbiter.sv
operand_requester.sv
tb_operand_requester.sv

// ==== tb_operand_requester.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "vrf_defines.svh"

module tb_operand_requester;

  localparam int CLK_PERIOD   = 100;
  localparam int BANK_W       = `BANK_W;
  localparam int READ_LIMIT   = 60;
  localparam int QUIET_CYCLES = 4;
  // Four read streams at most, plus the short write-back and reset sequences
  localparam int WATCHDOG_CYCLES = 2 * (4 * (READ_LIMIT + QUIET_CYCLES + 4) + 60);

  localparam int Q_ALU_A   = int'(vrf_pkg::ALU_A);
  localparam int Q_ALU_B   = int'(vrf_pkg::ALU_B);
  localparam int Q_STORE_A = int'(vrf_pkg::STORE_A);

  logic clk_i = 1'b0;
  logic rst_ni;

  vrf_pkg::operand_request_t [`NR_OPQ-1:0] op_req_i;
  logic [`NR_OPQ-1:0]                      op_req_valid_i;
  logic [`NR_OPQ-1:0]                      op_req_ready_o;
  logic [`NR_OPQ-1:0]                      opq_ready_i;
  vrf_pkg::opqueue_cmd_t [`NR_OPQ-1:0]     opq_cmd_o;
  logic [`NR_OPQ-1:0]                      opq_cmd_valid_o;
  logic [`NR_OPQ-1:0]                      operand_issued_o;
  vrf_pkg::wb_result_t                     alu_res_i;
  logic                                    alu_req_i;
  logic                                    alu_gnt_o;
  vrf_pkg::wb_result_t                     ldu_res_i;
  logic                                    ldu_req_i;
  logic                                    ldu_gnt_o;
  logic                                    ldu_final_gnt_o;
  vrf_pkg::vrf_req_t [`NR_BANKS-1:0]       vrf_o;
  logic [`NR_BANKS-1:0]                    vrf_valid_o;

  int          mismatch_count = 0;
  int          failure_count  = 0;
  logic [31:0] lfsr_state;

  operand_requester operand_requester_inst (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .op_req_i        (op_req_i),
    .op_req_valid_i  (op_req_valid_i),
    .op_req_ready_o  (op_req_ready_o),
    .opq_ready_i     (opq_ready_i),
    .opq_cmd_o       (opq_cmd_o),
    .opq_cmd_valid_o (opq_cmd_valid_o),
    .operand_issued_o(operand_issued_o),
    .alu_res_i       (alu_res_i),
    .alu_req_i       (alu_req_i),
    .alu_gnt_o       (alu_gnt_o),
    .ldu_res_i       (ldu_res_i),
    .ldu_req_i       (ldu_req_i),
    .ldu_gnt_o       (ldu_gnt_o),
    .ldu_final_gnt_o (ldu_final_gnt_o),
    .vrf_o           (vrf_o),
    .vrf_valid_o     (vrf_valid_o)
  );

  always #(CLK_PERIOD / 2) clk_i = ~clk_i;

  //////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////

  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
    if (got !== exp) begin
      $display("MISMATCH %s: got 0x%0h, expected 0x%0h", name, got, exp);
      mismatch_count++;
    end
  endtask

  task automatic report_failure(input string what);
    $display("ERROR: %s", what);
    failure_count++;
  endtask

  // Galois form, one step per random bit
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    if (s[0]) begin
      return (s >> 1) ^ 32'hb4bc_d35c;
    end else begin
      return s >> 1;
    end
  endfunction

  task automatic draw_ready(input int q);
    lfsr_state     = lfsr_step(lfsr_state);
    opq_ready_i[q] = lfsr_state[0];
  endtask

  // Each 64-bit word holds 8 >> eew elements
  function automatic int words_for(input int vl, input vrf_pkg::vew_e eew);
    int per_word;
    per_word = 8 >> int'(eew);
    return (vl + per_word - 1) / per_word;
  endfunction

  function automatic vrf_pkg::operand_request_t make_cmd(input logic [4:0] vs,
      input logic [`VL_W-1:0] vl, input vrf_pkg::vew_e eew);
    vrf_pkg::operand_request_t cmd;
    cmd.id  = '0;
    cmd.vs  = vs;
    cmd.vl  = vl;
    cmd.eew = eew;
    return cmd;
  endfunction

  function automatic vrf_pkg::wb_result_t make_result(input logic [7:0] addr,
      input logic [63:0] wdata, input logic [7:0] be);
    vrf_pkg::wb_result_t res;
    res.addr  = addr;
    res.wdata = wdata;
    res.be    = be;
    return res;
  endfunction

  task automatic apply_reset();
    rst_ni = 1'b0;
    repeat (2) @(posedge clk_i);
    check_value("op_req_ready_o", 64'(op_req_ready_o), 64'(0));
    check_value("opq_cmd_valid_o", 64'(opq_cmd_valid_o), 64'(0));
    check_value("operand_issued_o", 64'(operand_issued_o), 64'(0));
    check_value("vrf_valid_o", 64'(vrf_valid_o), 64'(0));
    check_value("alu_gnt_o", 64'(alu_gnt_o), 64'(0));
    check_value("ldu_final_gnt_o", 64'(ldu_final_gnt_o), 64'(0));
    // Empty load register accepts at once
    check_value("ldu_gnt_o", 64'(ldu_gnt_o), 64'(1));
    @(negedge clk_i);
    rst_ni = 1'b1;
  endtask

  // Called on a falling edge, returns on a falling edge
  task automatic send_cmd(input int q, input vrf_pkg::operand_request_t cmd);
    op_req_i[q]       = cmd;
    op_req_valid_i[q] = 1'b1;
    @(posedge clk_i);
    check_value("op_req_ready_o", 64'(op_req_ready_o[q]), 64'(1));
    check_value("opq_cmd_valid_o", 64'(opq_cmd_valid_o[q]), 64'(cmd.vl != '0));
    if (cmd.vl != '0) begin
      check_value("opq_cmd_o.elem_count", 64'(opq_cmd_o[q].elem_count), 64'(cmd.vl));
      check_value("opq_cmd_o.eew", 64'(opq_cmd_o[q].eew), 64'(cmd.eew));
    end
    // No read can leave in the accept cycle
    check_value("vrf_valid_o", 64'(vrf_valid_o), 64'(0));
    @(negedge clk_i);
    op_req_valid_i[q] = 1'b0;
    op_req_i[q]       = '0;
  endtask

  task automatic expect_quiet(input int q);
    repeat (QUIET_CYCLES) begin
      @(posedge clk_i);
      check_value("operand_issued_o", 64'(operand_issued_o[q]), 64'(0));
      check_value("opq_cmd_valid_o", 64'(opq_cmd_valid_o[q]), 64'(0));
      check_value("vrf_valid_o", 64'(vrf_valid_o), 64'(0));
      @(negedge clk_i);
    end
  endtask

  // Bank and row follow from the word address, one word per issued pulse
  task automatic collect_reads(input int q, input int start_addr, input int n,
                               input bit random_ready);
    int addr;
    int got;
    int cycles;
    int b;
    addr   = start_addr;
    got    = 0;
    cycles = 0;
    if (random_ready) begin
      draw_ready(q);
    end
    while (got < n && cycles < READ_LIMIT) begin
      @(posedge clk_i);
      cycles++;
      b = addr % `NR_BANKS;
      if (!opq_ready_i[q]) begin
        // A stalled queue sees no read at all
        check_value("operand_issued_o", 64'(operand_issued_o[q]), 64'(0));
        check_value("vrf_valid_o", 64'(vrf_valid_o), 64'(0));
      end else if (operand_issued_o[q]) begin
        check_value("vrf_valid_o", 64'(vrf_valid_o), 64'(1) << b);
        check_value("vrf_o.row", 64'(vrf_o[b].row), 64'(addr >> BANK_W));
        check_value("vrf_o.wen", 64'(vrf_o[b].wen), 64'(0));
        check_value("vrf_o.opqueue", 64'(vrf_o[b].opqueue), 64'(q));
        addr++;
        got++;
      end
      @(negedge clk_i);
      if (random_ready) begin
        draw_ready(q);
      end
    end
    opq_ready_i[q] = 1'b1;
    if (got != n) begin
      report_failure($sformatf("queue %0d delivered %0d of %0d reads within %0d cycles",
                               q, got, n, READ_LIMIT));
    end
    expect_quiet(q);
  endtask

  task automatic check_write(input int b, input vrf_pkg::wb_result_t res);
    check_value("vrf_valid_o", 64'(vrf_valid_o), 64'(1) << b);
    check_value("vrf_o.wen", 64'(vrf_o[b].wen), 64'(1));
    check_value("vrf_o.row", 64'(vrf_o[b].row), 64'(res.addr >> BANK_W));
    check_value("vrf_o.wdata", vrf_o[b].wdata, res.wdata);
    check_value("vrf_o.be", 64'(vrf_o[b].be), 64'(res.be));
  endtask

  //////////////////////////////////////////////////
  // Directed tests
  //////////////////////////////////////////////////

  task automatic test_single_read();
    send_cmd(Q_ALU_A, make_cmd(5'd2, 7'd16, vrf_pkg::EW64));
    collect_reads(Q_ALU_A, 2 * `WORDS_PER_REG, words_for(16, vrf_pkg::EW64), 1'b0);
  endtask

  task automatic test_narrow_elements();
    send_cmd(Q_ALU_B, make_cmd(5'd5, 7'd20, vrf_pkg::EW8));
    collect_reads(Q_ALU_B, 5 * `WORDS_PER_REG, words_for(20, vrf_pkg::EW8), 1'b0);
  endtask

  task automatic test_zero_length();
    send_cmd(Q_STORE_A, make_cmd(5'd4, 7'd0, vrf_pkg::EW16));
    expect_quiet(Q_STORE_A);
  endtask

  task automatic test_queue_backpressure();
    send_cmd(Q_ALU_A, make_cmd(5'd7, 7'd12, vrf_pkg::EW32));
    collect_reads(Q_ALU_A, 7 * `WORDS_PER_REG, words_for(12, vrf_pkg::EW32), 1'b1);
  endtask

  task automatic test_alu_writeback();
    vrf_pkg::wb_result_t res;
    res       = make_result(8'h25, 64'h0123_4567_89ab_cdef, 8'h0f);
    alu_res_i = res;
    alu_req_i = 1'b1;
    @(posedge clk_i);
    check_value("alu_gnt_o", 64'(alu_gnt_o), 64'(1));
    check_write(int'(res.addr[BANK_W-1:0]), res);
    @(negedge clk_i);
    alu_req_i = 1'b0;
    alu_res_i = '0;
  endtask

  task automatic test_load_writeback();
    vrf_pkg::wb_result_t res;
    int                  b;
    int                  cycles;
    bit                  seen;
    res       = make_result(8'h2e, 64'hcafe_f00d_1234_5678, 8'hf0);
    b         = int'(res.addr[BANK_W-1:0]);
    ldu_res_i = res;
    ldu_req_i = 1'b1;
    @(posedge clk_i);
    check_value("ldu_gnt_o", 64'(ldu_gnt_o), 64'(1));
    // Registered path, nothing reaches a bank yet
    check_value("vrf_valid_o", 64'(vrf_valid_o), 64'(0));
    @(negedge clk_i);
    ldu_req_i = 1'b0;
    ldu_res_i = '0;
    seen      = 1'b0;
    cycles    = 0;
    while (!seen && cycles < 10) begin
      @(posedge clk_i);
      cycles++;
      check_value("ldu_final_gnt_o", 64'(ldu_final_gnt_o), 64'(0));
      if (vrf_valid_o[b]) begin
        seen = 1'b1;
        check_write(b, res);
      end
      @(negedge clk_i);
    end
    if (!seen) begin
      report_failure("load result never reached its bank");
    end else begin
      @(posedge clk_i);
      check_value("ldu_final_gnt_o", 64'(ldu_final_gnt_o), 64'(1));
      @(negedge clk_i);
      @(posedge clk_i);
      check_value("ldu_final_gnt_o", 64'(ldu_final_gnt_o), 64'(0));
      @(negedge clk_i);
    end
  endtask

  // STORE_A is low priority, the ALU write-back high
  task automatic test_priority();
    vrf_pkg::wb_result_t res;
    send_cmd(Q_STORE_A, make_cmd(5'd3, 7'd2, vrf_pkg::EW64));
    res       = make_result(8'h10, 64'hdead_beef_0000_ffff, 8'hff);
    alu_res_i = res;
    alu_req_i = 1'b1;
    @(posedge clk_i);
    check_value("alu_gnt_o", 64'(alu_gnt_o), 64'(1));
    check_value("operand_issued_o", 64'(operand_issued_o[Q_STORE_A]), 64'(0));
    check_write(0, res);
    @(negedge clk_i);
    alu_req_i = 1'b0;
    alu_res_i = '0;
    collect_reads(Q_STORE_A, 3 * `WORDS_PER_REG, words_for(2, vrf_pkg::EW64), 1'b0);
  endtask

  //////////////////////////////////////////////////
  // Sequence and watchdog
  //////////////////////////////////////////////////

  initial begin
    rst_ni         = 1'b0;
    op_req_i       = '0;
    op_req_valid_i = '0;
    opq_ready_i    = '1;
    alu_res_i      = '0;
    alu_req_i      = 1'b0;
    ldu_res_i      = '0;
    ldu_req_i      = 1'b0;
    lfsr_state     = 32'h17b4;
    apply_reset();
    test_single_read();
    test_narrow_elements();
    test_zero_length();
    test_queue_backpressure();
    test_alu_writeback();
    test_load_writeback();
    test_priority();
    $display("Summary: %0d mismatches, %0d other failures", mismatch_count, failure_count);
    if (mismatch_count == 0 && failure_count == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("ERROR: watchdog expired after %0d cycles, the tests did not finish",
             WATCHDOG_CYCLES);
    $display("Summary: %0d mismatches, %0d other failures", mismatch_count,
             failure_count + 1);
    $display("Test failures found");
    $finish;
  end

endmodule

`default_nettype wire

// ==== vrf_defines.svh ====
`ifndef VRF_DEFINES_SVH
`define VRF_DEFINES_SVH

// Register-file organisation
`define NR_BANKS 4
`define BANK_W $clog2(`NR_BANKS)

// Operand queues plus the ALU and load-unit write-back ports
`define NR_OPQ 3
`define NR_MASTERS (`NR_OPQ + 2)

// One register-file word
`define ELEN 64

// Word address, low bits select the bank
`define VADDR_W 8
`define ROW_W (`VADDR_W - `BANK_W)

// Vector length and register geometry
`define VL_W 7
`define WORDS_PER_REG 8

// Instruction id
`define VID_W 2

`endif

// ==== vrf_pkg.sv ====
`default_nettype none

`include "vrf_defines.svh"

package vrf_pkg;

  typedef logic [`ELEN-1:0]   elen_t;
  typedef logic [`ELEN/8-1:0] strb_t;
  typedef logic [`VADDR_W-1:0] vaddr_t;

  typedef enum logic [1:0] {
    EW8,
    EW16,
    EW32,
    EW64
  } vew_e;

  // Target operand queue of a read
  typedef enum logic [1:0] {
    ALU_A,
    ALU_B,
    STORE_A
  } opqueue_e;

  typedef struct packed {
    logic [`VID_W-1:0] id;
    logic [4:0]        vs;
    logic [`VL_W-1:0]  vl;
    vew_e              eew;
  } operand_request_t;

  typedef struct packed {
    vew_e             eew;
    logic [`VL_W-1:0] elem_count;
  } opqueue_cmd_t;

  typedef struct packed {
    vaddr_t addr;
    elen_t  wdata;
    strb_t  be;
  } wb_result_t;

  // One access to a single bank
  typedef struct packed {
    logic [`ROW_W-1:0] row;
    logic              wen;
    elen_t             wdata;
    strb_t             be;
    opqueue_e          opqueue;
  } vrf_req_t;

  // Operand queues ALU_A and ALU_B plus the ALU write-back win over the rest
  localparam logic [`NR_MASTERS-1:0] HP_MASK = 5'b01011;

  localparam int unsigned VRF_BASE_STRIDE = `WORDS_PER_REG;

endpackage

`default_nettype wire
